//--- project.f
cpu_types_pkg.sv
microcode_sequencer.sv
regs.sv
alu.sv
nibble_datapath_top.sv
nibble_datapath_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the nibble datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module nibble_datapath_tb \
  -f project.f -o nibble_datapath_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/nibble_datapath_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1

//--- nibble_datapath_tb.sv
`default_nettype none

module nibble_datapath_tb
  import cpu_types_pkg::*;
();

  localparam int done_timeout = 8;

  typedef struct packed {
    reg_type                 src;
    reg_type                 dst;
    logic [nibble_width-1:0] immed;
    alu_op_type              op;
    logic                    hold_start;
    logic                    mem_op;
    logic [addr_width-1:0]   exp_addr;
    logic                    exp_wr;
    logic [nibble_width-1:0] exp_data;
    logic                    exp_carry;
    logic [15:0]             exp_count;
  } row_t;

  logic                    clk = 1'b0;
  logic                    arst_n;
  logic                    start;
  reg_type                 src;
  reg_type                 dst;
  logic [nibble_width-1:0] immed;
  alu_op_type              alu_op;
  logic [nibble_width-1:0] mem_read_data = '0;
  logic                    busy;
  logic                    done;
  logic                    carry;
  logic                    mem_write_en;
  logic [addr_width-1:0]   mem_addr;
  logic [nibble_width-1:0] mem_write_data;

  // Memory model
  logic [nibble_width-1:0] mem [4096];
  bit                      written [4096];
  int                      write_count = 0;

  // Expected state, indexed by register selector
  logic [nibble_width-1:0] m_reg [32];
  logic [nibble_width-1:0] exp_mem [4096];
  bit                      exp_written [4096];
  logic                    m_carry;
  int                      m_writes;
  row_t                    rows [$];
  integer                  seed;
  int                      errors;
  int                      timeouts;
  int                      checks;

  always #5 clk = ~clk;

  nibble_datapath_top nibble_datapath_top_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .start          (start),
    .src            (src),
    .dst            (dst),
    .immed          (immed),
    .alu_op         (alu_op),
    .mem_read_data  (mem_read_data),
    .busy           (busy),
    .done           (done),
    .carry          (carry),
    .mem_write_en   (mem_write_en),
    .mem_addr       (mem_addr),
    .mem_write_data (mem_write_data)
  );

  function automatic logic [nibble_width-1:0] fill_value(input logic [addr_width-1:0] a);
    return a[3:0] ^ a[7:4] ^ a[11:8];
  endfunction

  // One cycle registered read
  always @(posedge clk) begin
    if (mem_write_en) begin
      mem[mem_addr]     <= mem_write_data;
      written[mem_addr] <= 1'b1;
      write_count       <= write_count + 1;
    end
    mem_read_data <= written[mem_addr] ? mem[mem_addr] : fill_value(mem_addr);
  end

  function automatic logic is_memory(input reg_type sel);
    return (sel == REG_MX) || (sel == REG_MY) || (sel == REG_MSP) || (sel == REG_MN);
  endfunction

  function automatic logic [addr_width-1:0] addr_of(input reg_type sel,
                                                    input logic [nibble_width-1:0] imm);
    case (sel)
      REG_MX:  return {m_reg[REG_XP], m_reg[REG_XH], m_reg[REG_XL]};
      REG_MY:  return {m_reg[REG_YP], m_reg[REG_YH], m_reg[REG_YL]};
      REG_MSP: return {4'h0, m_reg[REG_SPH], m_reg[REG_SPL]};
      default: return {8'h00, imm};
    endcase
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  // ----------------------------------------------------------------------
  // Table building with the reference model
  // ----------------------------------------------------------------------
  task automatic add_row(input reg_type s, input reg_type d, input logic [3:0] imm,
                         input alu_op_type op, input logic hold);
    row_t       r;
    logic [3:0] bus_val;
    logic [3:0] ta;
    logic [3:0] tb;
    r = '0;
    r.src = s;
    r.dst = d;
    r.immed = imm;
    r.op = op;
    r.hold_start = hold;
    r.mem_op = is_memory(s) || is_memory(d);
    r.exp_addr = is_memory(s) ? addr_of(s, imm) : addr_of(d, imm);
    ta = m_reg[REG_TEMPA];
    tb = m_reg[REG_TEMPB];
    if (s == REG_IMM) begin
      bus_val = imm;
    end else if (s == REG_ALU) begin
      m_carry = 1'b0;
      case (op)
        ALU_ADD: begin
          bus_val = ta + tb;
          m_carry = (int'(ta) + int'(tb)) > 15;
        end
        ALU_SUB: begin
          bus_val = ta - tb;
          m_carry = (ta < tb);
        end
        ALU_AND: bus_val = ta & tb;
        ALU_OR:  bus_val = ta | tb;
        default: bus_val = ta ^ tb;
      endcase
    end else if (is_memory(s)) begin
      bus_val = exp_written[r.exp_addr] ? exp_mem[r.exp_addr] : fill_value(r.exp_addr);
    end else begin
      bus_val = m_reg[s];
    end
    if (is_memory(d)) begin
      r.exp_wr = 1'b1;
      r.exp_data = bus_val;
      exp_mem[r.exp_addr] = bus_val;
      exp_written[r.exp_addr] = 1'b1;
      m_writes++;
    end else begin
      m_reg[d] = bus_val;
    end
    r.exp_carry = m_carry;
    r.exp_count = 16'(m_writes);
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    foreach (m_reg[i]) m_reg[i] = '0;
    m_carry = 1'b0;
    m_writes = 0;
    add_row(REG_A, REG_MN, 4'h0, ALU_ADD, 1'b0);
    add_row(REG_IMM, REG_A, 4'h9, ALU_ADD, 1'b0);
    add_row(REG_A, REG_TEMPB, 4'h0, ALU_ADD, 1'b0);
    add_row(REG_TEMPB, REG_MN, 4'hc, ALU_ADD, 1'b0);
    // Pointers built nibble by nibble
    add_row(REG_IMM, REG_XL, 4'h3, ALU_ADD, 1'b0);
    add_row(REG_IMM, REG_XH, 4'ha, ALU_ADD, 1'b0);
    add_row(REG_IMM, REG_XP, 4'h5, ALU_ADD, 1'b0);
    add_row(REG_A, REG_MX, 4'h0, ALU_ADD, 1'b1);
    add_row(REG_IMM, REG_B, 4'h6, ALU_ADD, 1'b0);
    add_row(REG_IMM, REG_YL, 4'he, ALU_ADD, 1'b0);
    add_row(REG_IMM, REG_YH, 4'h1, ALU_ADD, 1'b0);
    add_row(REG_IMM, REG_YP, 4'hc, ALU_ADD, 1'b0);
    add_row(REG_B, REG_MY, 4'h0, ALU_ADD, 1'b0);
    add_row(REG_IMM, REG_SPL, 4'h7, ALU_ADD, 1'b0);
    add_row(REG_IMM, REG_SPH, 4'hd, ALU_ADD, 1'b0);
    add_row(REG_A, REG_MSP, 4'h0, ALU_ADD, 1'b0);
    // Reads back through every pointer
    add_row(REG_MX, REG_B, 4'h0, ALU_ADD, 1'b0);
    add_row(REG_B, REG_MN, 4'h1, ALU_ADD, 1'b0);
    add_row(REG_MY, REG_A, 4'h0, ALU_ADD, 1'b0);
    add_row(REG_A, REG_MN, 4'h2, ALU_ADD, 1'b0);
    add_row(REG_MSP, REG_TEMPA, 4'h0, ALU_ADD, 1'b0);
    add_row(REG_TEMPA, REG_MN, 4'h3, ALU_ADD, 1'b0);
    add_row(REG_MN, REG_B, 4'h2, ALU_ADD, 1'b0);
    add_row(REG_B, REG_MN, 4'h4, ALU_ADD, 1'b0);
    add_row(REG_IMM, REG_XP, 4'h8, ALU_ADD, 1'b0);
    add_row(REG_MX, REG_A, 4'h0, ALU_ADD, 1'b0);
    add_row(REG_A, REG_MN, 4'h5, ALU_ADD, 1'b0);
    for (int k = 0; k < 5; k++) begin
      rnd_a = $random(seed);
      rnd_b = $random(seed);
      add_row(REG_IMM, REG_TEMPA, rnd_a[3:0], ALU_ADD, 1'b0);
      add_row(REG_IMM, REG_TEMPB, rnd_b[3:0], ALU_ADD, 1'b0);
      add_row(REG_ALU, REG_MN, 4'h7, alu_op_type'(k), k == 4);
    end
  endtask

  // ----------------------------------------------------------------------
  // Applying one row
  // ----------------------------------------------------------------------
  task automatic apply_row(input int idx);
    row_t r;
    int   waited;
    r = rows[idx];
    src = r.src;
    dst = r.dst;
    immed = r.immed;
    alu_op = r.op;
    start = 1'b1;
    @(negedge clk);
    if (!r.hold_start) begin
      start = 1'b0;
    end
    check("busy in fetch", 32'(busy), 1);
    check("done in fetch", 32'(done), 0);
    if (r.mem_op) begin
      check("fetch address", 32'(mem_addr), 32'(r.exp_addr));
    end
    waited = 0;
    while (!done && waited < done_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (!done) begin
      timeouts++;
      $display("Row %0d: done did not rise within %0d cycles", idx, done_timeout);
    end else begin
      check("cycles from fetch to done", 32'(waited), 1);
      check("busy in write", 32'(busy), 1);
      check("write enable", 32'(mem_write_en), 32'(r.exp_wr));
      if (r.exp_wr) begin
        check("write address", 32'(mem_addr), 32'(r.exp_addr));
        check("write data", 32'(mem_write_data), 32'(r.exp_data));
      end
    end
    @(negedge clk);
    start = 1'b0;
    // Start held through the whole microinstruction must not restart it
    if (r.hold_start) begin
      repeat (2) @(negedge clk);
    end
    check("busy when idle", 32'(busy), 0);
    check("done when idle", 32'(done), 0);
    check("carry", 32'(carry), 32'(r.exp_carry));
    check("memory write count", 32'(write_count), 32'(r.exp_count));
  endtask

  initial begin
    seed = 32'h82476829;
    errors = 0;
    timeouts = 0;
    checks = 0;
    arst_n = 1'b0;
    start = 1'b0;
    src = REG_NONE;
    dst = REG_NONE;
    immed = '0;
    alu_op = ALU_ADD;
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check("busy after reset", 32'(busy), 0);
    check("done after reset", 32'(done), 0);
    check("write enable after reset", 32'(mem_write_en), 0);
    check("carry after reset", 32'(carry), 0);
    check("address after reset", 32'(mem_addr), 0);
    foreach (rows[i]) begin
      apply_row(i);
    end
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- nibble_datapath_top.sv
`default_nettype none

module nibble_datapath_top
  import cpu_types_pkg::*;
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    start,
  input  reg_type                 src,
  input  reg_type                 dst,
  input  logic [nibble_width-1:0] immed,
  input  alu_op_type              alu_op,
  input  logic [nibble_width-1:0] mem_read_data,
  output logic                    busy,
  output logic                    done,
  output logic                    carry,
  output logic                    mem_write_en,
  output logic [addr_width-1:0]   mem_addr,
  output logic [nibble_width-1:0] mem_write_data
);

  microcode_cycle          current_cycle;
  logic [nibble_width-1:0] temp_a;
  logic [nibble_width-1:0] temp_b;
  logic [nibble_width-1:0] alu_result;

  // ----------------------------------------------------------------------
  // Sequencer
  // ----------------------------------------------------------------------
  microcode_sequencer microcode_sequencer_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .start         (start),
    .current_cycle (current_cycle),
    .busy          (busy),
    .done          (done)
  );

  // ----------------------------------------------------------------------
  // Register block and ALU
  // ----------------------------------------------------------------------
  regs regs_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .current_cycle  (current_cycle),
    .src            (src),
    .dst            (dst),
    .immed          (immed),
    .alu_result     (alu_result),
    .mem_read_data  (mem_read_data),
    .temp_a         (temp_a),
    .temp_b         (temp_b),
    .mem_write_en   (mem_write_en),
    .mem_addr       (mem_addr),
    .mem_write_data (mem_write_data)
  );

  alu alu_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .current_cycle (current_cycle),
    .src           (src),
    .alu_op        (alu_op),
    .temp_a        (temp_a),
    .temp_b        (temp_b),
    .alu_result    (alu_result),
    .carry         (carry)
  );

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu
  import cpu_types_pkg::*;
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  microcode_cycle          current_cycle,
  input  reg_type                 src,
  input  alu_op_type              alu_op,
  input  logic [nibble_width-1:0] temp_a,
  input  logic [nibble_width-1:0] temp_b,
  output logic [nibble_width-1:0] alu_result,
  output logic                    carry
);

  // Extra top bit holds carry out or borrow
  logic [nibble_width:0] wide_result;
  logic                  carry_next;

  always_comb begin
    case (alu_op)
      ALU_ADD: wide_result = {1'b0, temp_a} + {1'b0, temp_b};
      ALU_SUB: wide_result = {1'b0, temp_a} - {1'b0, temp_b};
      ALU_AND: wide_result = {1'b0, temp_a & temp_b};
      ALU_OR:  wide_result = {1'b0, temp_a | temp_b};
      ALU_XOR: wide_result = {1'b0, temp_a ^ temp_b};
      default: wide_result = '0;
    endcase
  end

  assign alu_result = wide_result[nibble_width-1:0];
  assign carry_next = wide_result[nibble_width];

  // Flag only changes when the result is consumed
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      carry <= 1'b0;
    end else if (current_cycle == CYCLE_WRITE && src == REG_ALU) begin
      carry <= carry_next;
    end
  end

  // Only defined opcodes may feed a consumed result
  assert property (@(posedge clk) disable iff (!arst_n)
    (current_cycle == CYCLE_WRITE && src == REG_ALU) |->
      alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR});

endmodule

`default_nettype wire

//--- regs.sv
`default_nettype none

module regs
  import cpu_types_pkg::*;
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  microcode_cycle          current_cycle,
  input  reg_type                 src,
  input  reg_type                 dst,
  input  logic [nibble_width-1:0] immed,
  input  logic [nibble_width-1:0] alu_result,
  input  logic [nibble_width-1:0] mem_read_data,
  output logic [nibble_width-1:0] temp_a,
  output logic [nibble_width-1:0] temp_b,
  output logic                    mem_write_en,
  output logic [addr_width-1:0]   mem_addr,
  output logic [nibble_width-1:0] mem_write_data
);

  localparam int sp_width = 2 * nibble_width;

  logic [nibble_width-1:0] reg_a;
  logic [nibble_width-1:0] reg_b;
  logic [addr_width-1:0]   ptr_x;
  logic [addr_width-1:0]   ptr_y;
  logic [sp_width-1:0]     ptr_sp;
  logic [addr_width-1:0]   mem_addr_q;
  logic [nibble_width-1:0] bus;
  logic [addr_width-1:0]   fetch_addr;
  logic                    fetch_active;
  reg_type                 mem_sel;

  function automatic logic is_mem(reg_type sel);
    return sel inside {REG_MX, REG_MY, REG_MSP, REG_MN};
  endfunction

  // ----------------------------------------------------------------------
  // Bus source mux
  // ----------------------------------------------------------------------
  always_comb begin
    case (src)
      REG_A:     bus = reg_a;
      REG_B:     bus = reg_b;
      REG_TEMPA: bus = temp_a;
      REG_TEMPB: bus = temp_b;
      REG_XL:    bus = ptr_x[0 +: nibble_width];
      REG_XH:    bus = ptr_x[nibble_width +: nibble_width];
      REG_XP:    bus = ptr_x[2*nibble_width +: nibble_width];
      REG_YL:    bus = ptr_y[0 +: nibble_width];
      REG_YH:    bus = ptr_y[nibble_width +: nibble_width];
      REG_YP:    bus = ptr_y[2*nibble_width +: nibble_width];
      REG_SPL:   bus = ptr_sp[0 +: nibble_width];
      REG_SPH:   bus = ptr_sp[nibble_width +: nibble_width];
      REG_MX, REG_MY, REG_MSP, REG_MN: bus = mem_read_data;
      REG_IMM:   bus = immed;
      REG_ALU:   bus = alu_result;
      default:   bus = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Memory address generation
  // ----------------------------------------------------------------------
  // Source operand wins when both are memory
  assign mem_sel      = is_mem(src) ? src : dst;
  assign fetch_active = (current_cycle == CYCLE_FETCH) && (is_mem(src) || is_mem(dst));

  always_comb begin
    case (mem_sel)
      REG_MX:  fetch_addr = ptr_x;
      REG_MY:  fetch_addr = ptr_y;
      REG_MSP: fetch_addr = {{(addr_width-sp_width){1'b0}}, ptr_sp};
      default: fetch_addr = {{(addr_width-nibble_width){1'b0}}, immed};
    endcase
  end

  // Address is live during fetch, then held for the write cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_addr_q <= '0;
    end else if (fetch_active) begin
      mem_addr_q <= fetch_addr;
    end
  end

  assign mem_addr       = fetch_active ? fetch_addr : mem_addr_q;
  assign mem_write_en   = (current_cycle == CYCLE_WRITE) && is_mem(dst);
  assign mem_write_data = bus;

  // ----------------------------------------------------------------------
  // Destination write
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_a  <= '0;
      reg_b  <= '0;
      temp_a <= '0;
      temp_b <= '0;
      ptr_x  <= '0;
      ptr_y  <= '0;
      ptr_sp <= '0;
    end else if (current_cycle == CYCLE_WRITE) begin
      case (dst)
        REG_A:     reg_a <= bus;
        REG_B:     reg_b <= bus;
        REG_TEMPA: temp_a <= bus;
        REG_TEMPB: temp_b <= bus;
        REG_XL:    ptr_x[0 +: nibble_width] <= bus;
        REG_XH:    ptr_x[nibble_width +: nibble_width] <= bus;
        REG_XP:    ptr_x[2*nibble_width +: nibble_width] <= bus;
        REG_YL:    ptr_y[0 +: nibble_width] <= bus;
        REG_YH:    ptr_y[nibble_width +: nibble_width] <= bus;
        REG_YP:    ptr_y[2*nibble_width +: nibble_width] <= bus;
        REG_SPL:   ptr_sp[0 +: nibble_width] <= bus;
        REG_SPH:   ptr_sp[nibble_width +: nibble_width] <= bus;
        // Memory destinations go out through mem_write_en
        default: ;
      endcase
    end
  end

  // No memory to memory moves while a microinstruction runs
  assert property (@(posedge clk) disable iff (!arst_n)
    (current_cycle != CYCLE_NONE) |-> !(is_mem(src) && is_mem(dst)));

  // A write always follows a fetch of the same microinstruction
  assert property (@(posedge clk) disable iff (!arst_n)
    mem_write_en |-> (current_cycle == CYCLE_WRITE) && ($past(current_cycle) == CYCLE_FETCH));

endmodule

`default_nettype wire

//--- microcode_sequencer.sv
`default_nettype none

module microcode_sequencer
  import cpu_types_pkg::*;
(
  input  logic           clk,
  input  logic           arst_n,
  input  logic           start,
  output microcode_cycle current_cycle,
  output logic           busy,
  output logic           done
);

  microcode_cycle state;
  microcode_cycle state_next;

  always_comb begin
    state_next = state;
    case (state)
      CYCLE_NONE: begin
        // Start is ignored unless idle
        if (start) begin
          state_next = CYCLE_FETCH;
        end
      end
      CYCLE_FETCH: state_next = CYCLE_WRITE;
      CYCLE_WRITE: state_next = CYCLE_NONE;
      default:     state_next = CYCLE_NONE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= CYCLE_NONE;
    end else begin
      state <= state_next;
    end
  end

  assign current_cycle = state;
  assign busy          = (state != CYCLE_NONE);
  assign done          = (state == CYCLE_WRITE);

  // Encoding 2'b11 is never reached
  assert property (@(posedge clk) disable iff (!arst_n)
    state inside {CYCLE_NONE, CYCLE_FETCH, CYCLE_WRITE});

endmodule

`default_nettype wire

//--- cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

  localparam int nibble_width = 4;
  localparam int addr_width   = 12;

  // ----------------------------------------------------------------------
  // Bus sources and destinations
  // ----------------------------------------------------------------------
  typedef enum logic [4:0] {
    REG_A,
    REG_B,
    REG_TEMPA,
    REG_TEMPB,
    REG_XL,
    REG_XH,
    REG_XP,
    REG_YL,
    REG_YH,
    REG_YP,
    REG_SPL,
    REG_SPH,
    REG_MX,
    REG_MY,
    REG_MSP,
    REG_MN,
    REG_IMM,
    REG_ALU,
    REG_NONE
  } reg_type;

  // Phase of the current microinstruction
  typedef enum logic [1:0] {
    CYCLE_NONE,
    CYCLE_FETCH,
    CYCLE_WRITE
  } microcode_cycle;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_type;

endpackage

`default_nettype wire
